// File: Makefile
RTL = logic/huff_pkg.sv logic/huff_controller.sv logic/huff_histogram.sv \
      logic/huff_tree_build.sv logic/huff_codebook.sv logic/huff_translate.sv \
      logic/huff_top.sv

all: run

run:
	verilator --binary --timing --assert -f src.f --top-module huff_tb -o huff_tb
	@out="$$(./obj_dir/huff_tb 2>&1)"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing --top-module huff_top $(RTL)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

// File: dv/huff_ref.svh
`ifndef HUFF_REF_SVH
`define HUFF_REF_SVH

// histogram of the symbols queued for the current block
function automatic huff_pkg::count_vec_t block_counts();
  huff_pkg::count_vec_t cnt;
  cnt = '0;
  foreach (blk_q[k]) begin
    cnt[blk_q[k]] = cnt[blk_q[k]] + 8'd1;
  end
  return cnt;
endfunction

// code lengths by merging the two least weights
// least1 then least2, lower index first on a tie, merged into the lower slot
function automatic huff_pkg::len_vec_t ref_lens(input huff_pkg::count_vec_t cnt);
  int                 w [8];
  logic [7:0]         msk [8];
  logic [7:0]         act;
  int                 n_act;
  int                 l1;
  int                 l2;
  int                 lo;
  int                 hi;
  huff_pkg::len_vec_t lv;
  lv = '0;
  n_act = 0;
  for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
    w[i] = int'(cnt[i]);
    act[i] = (cnt[i] != 8'd0);
    msk[i] = 8'(1) << i;
    if (act[i]) n_act++;
  end
  // lone symbol still gets one bit
  if (n_act == 1) begin
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      if (act[i]) lv[i] = 3'd1;
    end
  end
  while (n_act > 1) begin
    l1 = -1;
    l2 = -1;
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      if (act[i] && (l1 < 0 || w[i] < w[l1])) l1 = i;
    end
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      if (act[i] && i != l1 && (l2 < 0 || w[i] < w[l2])) l2 = i;
    end
    lo = (l1 < l2) ? l1 : l2;
    hi = (l1 < l2) ? l2 : l1;
    w[lo] = w[l1] + w[l2];
    msk[lo] = msk[l1] | msk[l2];
    act[hi] = 1'b0;
    n_act--;
    // leaves under the new node go one level deeper
    for (int i = 0; i < huff_pkg::NUM_SYMS; i++) begin
      if (msk[lo][i]) lv[i] = lv[i] + 3'd1;
    end
  end
  return lv;
endfunction

// canonical codes, lengths 1..7 outer, symbols 0..7 inner
function automatic huff_pkg::codebook_t ref_codes(input huff_pkg::len_vec_t lv);
  huff_pkg::codebook_t cb;
  int                  code;
  int                  prev_len;
  bit                  first;
  cb = '0;
  code = 0;
  prev_len = 0;
  first = 1'b1;
  for (int l = 1; l <= huff_pkg::CODE_W; l++) begin
    for (int s = 0; s < huff_pkg::NUM_SYMS; s++) begin
      if (int'(lv[s]) == l) begin
        if (!first) code = (code + 1) << (l - prev_len);
        first = 1'b0;
        prev_len = l;
        cb[s].code = 7'(code);
        cb[s].len = 3'(l);
      end
    end
  end
  return cb;
endfunction

// expected stream for the block, MSB first per symbol
function automatic void expect_block();
  huff_pkg::codebook_t cb;
  cb = ref_codes(ref_lens(block_counts()));
  foreach (blk_q[k]) begin
    for (int j = int'(cb[blk_q[k]].len) - 1; j >= 0; j--) begin
      exp_bits.push_back(cb[blk_q[k]].code[j]);
    end
  end
endfunction

`endif

// File: dv/huff_tb.sv
`timescale 1ns/1ps

module huff_tb;

  logic                hwclk;
  logic                rst_n_i;
  logic                sym_valid_i;
  huff_pkg::sym_beat_t sym_beat_i;
  logic                sym_ready_o;
  logic                bit_o;
  logic                bit_valid_o;
  logic                block_done_o;

  // current block and the bits it should turn into
  int    blk_q[$];
  bit    exp_bits[$];
  string test_name;
  int    seed = 32'h285e9315;
  // 4 random, single, fib, 2 gappy, 2 back to back
  int    blocks_planned = 10;
  // owned by the comparator
  int    bits_seen = 0;
  int    blocks_done = 0;

  `include "huff_ref.svh"

  huff_top huff_top_i (
    .hwclk(hwclk), .rst_n_i(rst_n_i),
    .sym_valid_i(sym_valid_i), .sym_beat_i(sym_beat_i), .sym_ready_o(sym_ready_o),
    .bit_o(bit_o), .bit_valid_o(bit_valid_o), .block_done_o(block_done_o)
  );

  always #50 hwclk = ~hwclk;

  task automatic check_val(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("FAIL %s expected %0d actual %0d", name, expected, actual);
      $display("tests failed");
      $fatal(1, "check mismatch");
    end
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "run stopped");
  endtask

  // one expected bit per valid bit, one done per block
  always @(posedge hwclk) begin
    if (rst_n_i && bit_valid_o) begin
      if (exp_bits.size() == 0) begin
        stop_run("DUT sent a code bit when no more bits were expected");
      end else begin
        check_val($sformatf("%s bit %0d", test_name, bits_seen),
                  int'(exp_bits.pop_front()), int'(bit_o));
        bits_seen++;
      end
    end
    if (rst_n_i && block_done_o) begin
      check_val($sformatf("%s bits left at block done", test_name), 0, exp_bits.size());
      blocks_done++;
    end
  end

  // beat held until ready seen at a falling edge, taken on the next rise
  task automatic send_beat(input int sym, input bit last);
    @(negedge hwclk);
    sym_valid_i     = 1'b1;
    sym_beat_i.sym  = 3'(sym);
    sym_beat_i.last = last;
    while (!sym_ready_o) begin
      @(negedge hwclk);
    end
  endtask

  // whole block once, random idle gaps when asked
  task automatic send_pass(input bit gaps);
    int idle;
    for (int k = 0; k < blk_q.size(); k++) begin
      if (gaps && ($unsigned($random(seed)) % 3 == 0)) begin
        idle = 1 + int'($unsigned($random(seed)) % 3);
        repeat (idle) begin
          @(negedge hwclk);
          sym_valid_i = 1'b0;
        end
      end
      send_beat(blk_q[k], k == blk_q.size() - 1);
    end
    @(negedge hwclk);
    sym_valid_i = 1'b0;
  endtask

  // count pass, encode pass, then wait for block done
  // nbits comes back as the number of bits the DUT sent
  task automatic run_block(input string name, input bit gaps, output int nbits);
    int bits_before;
    int done_before;
    test_name = name;
    expect_block();
    bits_before = bits_seen;
    done_before = blocks_done;
    send_pass(gaps);
    send_pass(gaps);
    wait (blocks_done == done_before + 1);
    nbits = bits_seen - bits_before;
  endtask

  // n symbols from base .. base+span-1
  task automatic make_block(input int n, input int base, input int span);
    blk_q.delete();
    repeat (n) begin
      blk_q.push_back(base + int'($unsigned($random(seed)) % span));
    end
  endtask

  task automatic make_fib_block();
    int fib [8];
    int j;
    int tmp;
    fib = '{1, 1, 2, 3, 5, 8, 13, 21};
    blk_q.delete();
    for (int s = 0; s < 8; s++) begin
      repeat (fib[s]) blk_q.push_back(s);
    end
    // interleave the symbols
    for (int k = blk_q.size() - 1; k > 0; k--) begin
      j = int'($unsigned($random(seed)) % (k + 1));
      tmp = blk_q[k];
      blk_q[k] = blk_q[j];
      blk_q[j] = tmp;
    end
  endtask

  initial begin
    int                 nbits;
    int                 maxl;
    huff_pkg::len_vec_t lv;
    hwclk = 1'b0;
    rst_n_i = 1'b0;
    sym_valid_i = 1'b0;
    sym_beat_i = '0;
    test_name = "reset";
    repeat (3) @(posedge hwclk);
    @(negedge hwclk);
    rst_n_i = 1'b1;
    @(negedge hwclk);
    check_val("reset sym_ready", 1, int'(sym_ready_o));
    check_val("reset bit_valid", 0, int'(bit_valid_o));
    check_val("reset block_done", 0, int'(block_done_o));

    for (int b = 0; b < 4; b++) begin
      make_block(20 + int'($unsigned($random(seed)) % 41), 0, 8);
      run_block($sformatf("random_%0d", b), 1'b0, nbits);
    end

    // one symbol only, each one a single 0 bit
    blk_q.delete();
    repeat (12) blk_q.push_back(5);
    run_block("single_sym", 1'b0, nbits);
    check_val("single_sym bit total", 12, nbits);

    // fibonacci weights push the deepest code to 7 bits
    make_fib_block();
    lv = ref_lens(block_counts());
    maxl = 0;
    for (int s = 0; s < 8; s++) begin
      if (int'(lv[s]) > maxl) maxl = int'(lv[s]);
    end
    check_val("fib_skew max length", 7, maxl);
    run_block("fib_skew", 1'b0, nbits);

    for (int b = 0; b < 2; b++) begin
      make_block(20 + int'($unsigned($random(seed)) % 41), 0, 8);
      run_block($sformatf("backpressure_%0d", b), 1'b1, nbits);
    end

    // low half then high half, stale counts would break the second
    make_block(40, 0, 4);
    run_block("b2b_low", 1'b0, nbits);
    make_block(30, 4, 4);
    run_block("b2b_high", 1'b0, nbits);

    $display("all tests passed");
    $finish;
  end

  // budget of 2000 cycles per block
  initial begin
    repeat (2000 * blocks_planned) @(posedge hwclk);
    stop_run("timeout: the DUT did not finish all blocks within the cycle budget");
  end

endmodule

// File: logic/huff_codebook.sv
`timescale 1ns/1ps

module huff_codebook (
  input  logic                hwclk,
  input  logic                rst_n_i,
  input  huff_pkg::phase_t    phase_i,
  input  huff_pkg::len_vec_t  lens_i,
  output huff_pkg::codebook_t book_o,
  output logic                code_done_o
);

  logic [huff_pkg::STEP_W-1:0] step_q;
  logic                        first_q;
  logic [huff_pkg::CODE_W-1:0] next_code_q;
  logic [huff_pkg::LEN_W-1:0]  prev_len_q;
  huff_pkg::codebook_t         book_q;

  logic                        in_code;
  logic [huff_pkg::SYM_W-1:0]  sym_cur;
  logic [huff_pkg::LEN_W-1:0]  len_cur;
  logic                        hit;
  logic [huff_pkg::CODE_W-1:0] code_new;

  assign in_code = (phase_i == huff_pkg::PH_CODE);

  // step splits into length (outer) and symbol (inner)
  assign sym_cur = step_q[huff_pkg::SYM_W-1:0];
  assign len_cur = step_q[huff_pkg::STEP_W-1:huff_pkg::SYM_W] + 1'b1;

  // symbol of the current length is present
  assign hit = in_code && (step_q < huff_pkg::STEP_W'(huff_pkg::CODE_STEPS)) &&
               (lens_i[sym_cur] == len_cur);

  // canonical rule: previous code plus one, widened to the new length
  assign code_new = first_q ? '0 : (next_code_q + 1'b1) << (len_cur - prev_len_q);

  // done once all 56 steps have run
  assign code_done_o = in_code && (step_q == huff_pkg::STEP_W'(huff_pkg::CODE_STEPS));

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      step_q      <= '0;
      first_q     <= 1'b1;
      next_code_q <= '0;
      prev_len_q  <= '0;
    end else if (!in_code) begin
      step_q      <= '0;
      first_q     <= 1'b1;
      next_code_q <= '0;
      prev_len_q  <= '0;
    end else if (!code_done_o) begin
      step_q <= step_q + 1'b1;
      if (hit) begin
        first_q     <= 1'b0;
        next_code_q <= code_new;
        prev_len_q  <= len_cur;
      end
    end
  end

  // entries wiped during build, so absent symbols read length zero
  always_ff @(posedge hwclk) begin
    if (phase_i == huff_pkg::PH_BUILD) begin
      book_q <= '0;
    end else if (hit) begin
      book_q[sym_cur].code <= code_new;
      book_q[sym_cur].len  <= len_cur;
    end
  end

  assign book_o = book_q;

  // codes handed out in increasing order
  a_code_grows: assert property (
    @(posedge hwclk) disable iff (!rst_n_i)
    (hit && !first_q) |-> (code_new > next_code_q)
  );

endmodule

// File: logic/huff_controller.sv
`timescale 1ns/1ps

module huff_controller (
  input  logic             hwclk,
  input  logic             rst_n_i,
  input  logic             count_done_i,
  input  logic             build_done_i,
  input  logic             code_done_i,
  input  logic             block_done_i,
  output huff_pkg::phase_t phase_o
);

  huff_pkg::phase_t phase_q;

  // phase sequence count, build, code, encode and back to count
  // a done pulse only moves the phase it belongs to
  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= huff_pkg::PH_COUNT;
    end else begin
      case (phase_q)
        huff_pkg::PH_COUNT:  if (count_done_i) phase_q <= huff_pkg::PH_BUILD;
        huff_pkg::PH_BUILD:  if (build_done_i) phase_q <= huff_pkg::PH_CODE;
        huff_pkg::PH_CODE:   if (code_done_i) phase_q <= huff_pkg::PH_ENCODE;
        huff_pkg::PH_ENCODE: if (block_done_i) phase_q <= huff_pkg::PH_COUNT;
        default:             phase_q <= huff_pkg::PH_COUNT;
      endcase
    end
  end

  assign phase_o = phase_q;

  // stages hand over one at a time, never two done pulses at once
  a_one_done: assert property (
    @(posedge hwclk) disable iff (!rst_n_i)
    $onehot0({count_done_i, build_done_i, code_done_i, block_done_i})
  );

endmodule

// File: logic/huff_histogram.sv
`timescale 1ns/1ps

module huff_histogram (
  input  logic                 hwclk,
  input  logic                 rst_n_i,
  input  huff_pkg::phase_t     phase_i,
  input  logic                 beat_valid_i,
  input  huff_pkg::sym_beat_t  beat_i,
  input  logic                 block_done_i,
  output huff_pkg::count_vec_t counts_o,
  output logic                 count_done_o
);

  huff_pkg::count_vec_t counts_q;
  logic                 take;

  // handshake is already resolved upstream, only the phase gates here
  assign take = beat_valid_i && (phase_i == huff_pkg::PH_COUNT);

  // per-symbol counters
  // cleared when the encode pass of the block finishes
  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      counts_q <= '0;
    end else if (block_done_i) begin
      counts_q <= '0;
    end else if (take) begin
      counts_q[beat_i.sym] <= counts_q[beat_i.sym] + 1'b1;
    end
  end

  assign counts_o = counts_q;

  // last beat of the count pass closes it
  // phase moves to build on the same edge, so ready drops right after
  assign count_done_o = take && beat_i.last;

  // a block larger than 255 symbols would wrap a counter
  a_no_overflow: assert property (
    @(posedge hwclk) disable iff (!rst_n_i)
    take |-> (counts_q[beat_i.sym] != '1)
  );

endmodule

// File: logic/huff_pkg.sv
package huff_pkg;

  // alphabet and field widths
  localparam int NUM_SYMS = 8;
  localparam int SYM_W = 3;
  // a block holds at most 255 symbols, so merged weights fit too
  localparam int CNT_W = 8;
  // code lengths never exceed 7 for 8 symbols
  localparam int LEN_W = 3;
  localparam int CODE_W = 7;

  // codebook walk, one step per (length, symbol) pair
  localparam int CODE_STEPS = NUM_SYMS * CODE_W;
  localparam int STEP_W = 6;

  // block phases, advanced by the controller
  typedef enum logic [1:0] {
    PH_COUNT  = 2'd0,
    PH_BUILD  = 2'd1,
    PH_CODE   = 2'd2,
    PH_ENCODE = 2'd3
  } phase_t;

  // one input beat
  typedef struct packed {
    logic [SYM_W-1:0] sym;
    // marks the last symbol of a pass
    logic             last;
  } sym_beat_t;

  // per-symbol occurrence counts
  typedef logic [NUM_SYMS-1:0][CNT_W-1:0] count_vec_t;

  // per-symbol code lengths, zero for an absent symbol
  typedef logic [NUM_SYMS-1:0][LEN_W-1:0] len_vec_t;

  // canonical code, right-aligned, with its length
  typedef struct packed {
    logic [CODE_W-1:0] code;
    logic [LEN_W-1:0]  len;
  } code_ent_t;

  typedef code_ent_t [NUM_SYMS-1:0] codebook_t;

endpackage

// File: logic/huff_top.sv
`timescale 1ns/1ps

module huff_top (
  input  logic                hwclk,
  input  logic                rst_n_i,
  input  logic                sym_valid_i,
  input  huff_pkg::sym_beat_t sym_beat_i,
  output logic                sym_ready_o,
  output logic                bit_o,
  output logic                bit_valid_o,
  output logic                block_done_o
);

  huff_pkg::phase_t     phase;
  huff_pkg::count_vec_t counts;
  huff_pkg::len_vec_t   lens;
  huff_pkg::codebook_t  book;
  logic                 count_done;
  logic                 build_done;
  logic                 code_done;
  logic                 tr_ready;
  logic                 accept;

  // ready by phase: always in count, translator idle in encode
  assign sym_ready_o = (phase == huff_pkg::PH_COUNT) ||
                       ((phase == huff_pkg::PH_ENCODE) && tr_ready);
  assign accept = sym_valid_i && sym_ready_o;

  huff_controller controller_i (
    .hwclk(hwclk), .rst_n_i(rst_n_i),
    .count_done_i(count_done), .build_done_i(build_done),
    .code_done_i(code_done), .block_done_i(block_done_o),
    .phase_o(phase)
  );

  huff_histogram histogram_i (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .phase_i(phase),
    .beat_valid_i(accept), .beat_i(sym_beat_i), .block_done_i(block_done_o),
    .counts_o(counts), .count_done_o(count_done)
  );

  huff_tree_build tree_build_i (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .phase_i(phase),
    .counts_i(counts), .lens_o(lens), .build_done_o(build_done)
  );

  huff_codebook codebook_i (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .phase_i(phase),
    .lens_i(lens), .book_o(book), .code_done_o(code_done)
  );

  huff_translate translate_i (
    .hwclk(hwclk), .rst_n_i(rst_n_i), .phase_i(phase),
    .beat_valid_i(accept), .beat_i(sym_beat_i), .book_i(book),
    .sym_ready_o(tr_ready), .bit_o(bit_o), .bit_valid_o(bit_valid_o),
    .block_done_o(block_done_o)
  );

endmodule

// File: logic/huff_translate.sv
`timescale 1ns/1ps

module huff_translate (
  input  logic                hwclk,
  input  logic                rst_n_i,
  input  huff_pkg::phase_t    phase_i,
  input  logic                beat_valid_i,
  input  huff_pkg::sym_beat_t beat_i,
  input  huff_pkg::codebook_t book_i,
  output logic                sym_ready_o,
  output logic                bit_o,
  output logic                bit_valid_o,
  output logic                block_done_o
);

  logic                        busy_q;
  logic [huff_pkg::LEN_W-1:0]  left_q;
  logic                        last_q;
  logic                        done_q;
  logic [huff_pkg::CODE_W-1:0] shreg_q;

  huff_pkg::code_ent_t         ent;
  logic                        take;

  // codebook lookup for the offered symbol
  assign ent = book_i[beat_i.sym];

  assign take = beat_valid_i && (phase_i == huff_pkg::PH_ENCODE) && !busy_q && !done_q;

  // idle only when neither shifting nor closing the block
  assign sym_ready_o = !busy_q && !done_q;

  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      left_q <= '0;
      last_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (take) begin
        busy_q <= 1'b1;
        left_q <= ent.len;
        last_q <= beat_i.last;
      end else if (busy_q) begin
        left_q <= left_q - 1'b1;
        if (left_q == huff_pkg::LEN_W'(1)) begin
          busy_q <= 1'b0;
          // final bit of the final symbol
          done_q <= last_q;
        end
      end
    end
  end

  // code moved to the top bits so the MSB leaves first
  always_ff @(posedge hwclk) begin
    if (take) begin
      shreg_q <= ent.code << (huff_pkg::LEN_W'(huff_pkg::CODE_W) - ent.len);
    end else if (busy_q) begin
      shreg_q <= shreg_q << 1;
    end
  end

  assign bit_o        = shreg_q[huff_pkg::CODE_W-1];
  assign bit_valid_o  = busy_q;
  assign block_done_o = done_q;

  // every symbol of the encode pass was seen in the count pass
  a_len_nonzero: assert property (
    @(posedge hwclk) disable iff (!rst_n_i)
    take |-> (ent.len != '0)
  );

  // bits only come out while the controller sits in encode
  a_bits_in_encode: assert property (
    @(posedge hwclk) disable iff (!rst_n_i)
    bit_valid_o |-> (phase_i == huff_pkg::PH_ENCODE)
  );

endmodule

// File: logic/huff_tree_build.sv
`timescale 1ns/1ps

module huff_tree_build (
  input  logic                 hwclk,
  input  logic                 rst_n_i,
  input  huff_pkg::phase_t     phase_i,
  input  huff_pkg::count_vec_t counts_i,
  output huff_pkg::len_vec_t   lens_o,
  output logic                 build_done_o
);

  localparam int N = huff_pkg::NUM_SYMS;

  // slot state: weight, leaf mask, active flag
  logic [N-1:0][huff_pkg::CNT_W-1:0] weight_q;
  logic [N-1:0][N-1:0]               mask_q;
  logic [N-1:0]                      active_q;
  logic                              started_q;
  huff_pkg::len_vec_t                lens_q;

  logic                              in_build;
  logic                              do_merge;
  logic [huff_pkg::SYM_W-1:0]        least1;
  logic [huff_pkg::SYM_W-1:0]        least2;
  logic                              found1;
  logic                              found2;
  logic [huff_pkg::SYM_W-1:0]        lo_idx;
  logic [huff_pkg::SYM_W-1:0]        hi_idx;
  logic [N-1:0]                      merged_mask;

  assign in_build = (phase_i == huff_pkg::PH_BUILD);

  // one active slot left means the tree is complete
  assign build_done_o = in_build && started_q && $onehot0(active_q);
  assign do_merge = in_build && started_q && !build_done_o;

  // two least active weights, lower index wins a tie
  always_comb begin
    least1 = '0;
    least2 = '0;
    found1 = 1'b0;
    found2 = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (active_q[i] && (!found1 || weight_q[i] < weight_q[least1])) begin
        least1 = huff_pkg::SYM_W'(i);
        found1 = 1'b1;
      end
    end
    for (int i = 0; i < N; i++) begin
      if (active_q[i] && (huff_pkg::SYM_W'(i) != least1) &&
          (!found2 || weight_q[i] < weight_q[least2])) begin
        least2 = huff_pkg::SYM_W'(i);
        found2 = 1'b1;
      end
    end
  end

  // merged node lands in the lower of the two slots
  assign lo_idx = (least1 < least2) ? least1 : least2;
  assign hi_idx = (least1 < least2) ? least2 : least1;
  assign merged_mask = mask_q[least1] | mask_q[least2];

  // control: load on entry, then retire one slot per merge
  always_ff @(posedge hwclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      started_q <= 1'b0;
      active_q  <= '0;
    end else if (!in_build) begin
      started_q <= 1'b0;
    end else if (!started_q) begin
      started_q <= 1'b1;
      for (int i = 0; i < N; i++) begin
        active_q[i] <= (counts_i[i] != '0);
      end
    end else if (do_merge) begin
      active_q[hi_idx] <= 1'b0;
    end
  end

  // weights, masks and leaf lengths
  always_ff @(posedge hwclk) begin
    if (in_build && !started_q) begin
      weight_q <= counts_i;
      lens_q   <= '0;
      for (int i = 0; i < N; i++) begin
        mask_q[i] <= N'(1) << i;
      end
    end else if (do_merge) begin
      weight_q[lo_idx] <= weight_q[least1] + weight_q[least2];
      mask_q[lo_idx]   <= merged_mask;
      // every leaf under the new node sinks one level
      for (int i = 0; i < N; i++) begin
        if (merged_mask[i]) lens_q[i] <= lens_q[i] + 1'b1;
      end
    end else if (build_done_o && lens_q == '0) begin
      // lone symbol, no merges, still needs a one-bit code
      for (int i = 0; i < N; i++) begin
        if (active_q[i]) lens_q[i] <= huff_pkg::LEN_W'(1);
      end
    end
  end

  assign lens_o = lens_q;

  // an empty block has nothing to build
  a_not_empty: assert property (
    @(posedge hwclk) disable iff (!rst_n_i)
    (in_build && !started_q) |-> (counts_i != '0)
  );

endmodule

// File: src.f
+incdir+dv
logic/huff_pkg.sv
logic/huff_controller.sv
logic/huff_histogram.sv
logic/huff_tree_build.sv
logic/huff_codebook.sv
logic/huff_translate.sv
logic/huff_top.sv
dv/huff_tb.sv
